// ==== src/ex_pkg.sv ====
/*
    shared types and vtype field positions for the execute stage
    imported by every module of the stage
*/
package ex_pkg;

    // data word for operands, results and addresses
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // operand a source
    typedef enum logic [1:0] {
        A_RS1   = 2'd0,
        A_IMM_S = 2'd1,
        A_PC    = 2'd2,
        A_ZERO  = 2'd3
    } alu_a_sel_t;

    // operand b source
    typedef enum logic [1:0] {
        B_RS1   = 2'd0,
        B_RS2   = 2'd1,
        B_IMM   = 2'd2,
        B_IMM_U = 2'd3
    } alu_b_sel_t;

    // conditional branch kind, BR_NONE for everything else
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_type_t;

    // vector configuration instruction kind
    typedef enum logic [1:0] {
        NOT_CFG  = 2'd0,
        VSETVLI  = 2'd1,
        VSETIVLI = 2'd2,
        VSETVL   = 2'd3
    } vsetvl_type_t;

    // element width, encodings 3..7 illegal
    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2
    } vsew_t;

    // register group multiplier, encoding 4 illegal
    typedef enum logic [2:0] {
        LMUL1      = 3'd0,
        LMUL2      = 3'd1,
        LMUL4      = 3'd2,
        LMUL8      = 3'd3,
        LMULEIGHTH = 3'd5,
        LMULFOURTH = 3'd6,
        LMULHALF   = 3'd7
    } vlmul_t;

    typedef logic [31:0] vtype_t;

    // vtype layout, bits 30..6 reserved
    localparam int VLMUL_LSB = 0;
    localparam int VSEW_LSB  = 3;
    localparam int VILL_BIT  = 31;

endpackage

// ==== src/reg_file.sv ====
/*
    32 x 32 integer register file, two async reads and one clocked write
    x0 always reads zero
*/
`timescale 1ns/1ns

module reg_file import ex_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wen,
    input  reg_idx_t rd,
    input  word_t    w_data
);

    // x1..x31 only, x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= w_data;
        end
    end

    // reads bypass nothing, write-back lands next edge
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/alu.sv ====
/*
    combinational RV32I integer alu
    shift amount comes from the low five bits of port_b
*/
`timescale 1ns/1ns

module alu import ex_pkg::*; (
    input  alu_op_t aluop,
    input  word_t   port_a,
    input  word_t   port_b,
    output word_t   port_out
);

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (aluop)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shamt;
            // compares give 0 or 1
            ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ALU_SLTU: port_out = {31'b0, port_a < port_b};
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_SRL:  port_out = port_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
            ALU_OR:   port_out = port_a | port_b;
            ALU_AND:  port_out = port_a & port_b;
            default:  port_out = '0;
        endcase
    end

endmodule

// ==== src/branch_jump_unit.sv ====
/*
    branch condition and branch/jal/jalr target resolution
    brj_addr is the next pc seen by fetch
*/
`timescale 1ns/1ns

module branch_jump_unit import ex_pkg::*; (
    input  word_t        pc,
    input  word_t        rs1_val,
    input  word_t        rs2_val,
    input  branch_type_t branch_type,
    input  logic [12:0]  imm_sb,
    input  logic [20:0]  imm_uj,
    input  word_t        imm_i_ext,
    input  logic         j_sel,
    input  logic         ex_pc_sel,
    output logic         branch_taken,
    output word_t        brj_addr
);

    word_t branch_addr;
    word_t jal_addr;
    word_t jalr_addr;
    word_t jump_addr;
    word_t pc4;

    // condition check
    always_comb begin
        case (branch_type)
            BR_EQ:   branch_taken = (rs1_val == rs2_val);
            BR_NE:   branch_taken = (rs1_val != rs2_val);
            BR_LT:   branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  branch_taken = (rs1_val < rs2_val);
            BR_GEU:  branch_taken = (rs1_val >= rs2_val);
            default: branch_taken = 1'b0;
        endcase
    end

    // pc-relative targets
    assign branch_addr = pc + {{19{imm_sb[12]}}, imm_sb};
    assign jal_addr    = pc + {{11{imm_uj[20]}}, imm_uj};

    // jalr drops bit 0 of the sum
    assign jalr_addr = (rs1_val + imm_i_ext) & ~word_t'(1);

    assign jump_addr = j_sel ? jal_addr : jalr_addr;
    assign pc4       = pc + 32'd4;

    // jumps win, then branch outcome
    always_comb begin
        if (ex_pc_sel) begin
            brj_addr = jump_addr;
        end else if (branch_taken) begin
            brj_addr = branch_addr;
        end else begin
            brj_addr = pc4;
        end
    end

endmodule

// ==== src/vcfg_unit.sv ====
/*
    vsetvl/vsetvli/vsetivli calculation of the new vl and vtype
    VLEN_BYTES sets the vector register length
*/
`timescale 1ns/1ns

module vcfg_unit import ex_pkg::*; #(
    parameter int VLEN_BYTES = 16
) (
    input  vsetvl_type_t vsetvl_type,
    input  word_t        rs1_val,
    input  word_t        rs2_val,
    input  reg_idx_t     rs1,
    input  logic [4:0]   zimm,
    input  vtype_t       vtype_imm,
    output word_t        new_vl,
    output vtype_t       new_vtype
);

    localparam word_t VLEN_W = word_t'(VLEN_BYTES);

    vtype_t vtype_req;
    word_t  avl;
    vsew_t  sew;
    vlmul_t lmul;
    logic   sew_ok;
    logic   lmul_ok;
    logic   rsvd_ok;
    logic   keep_max;
    word_t  vlmax_sew;
    word_t  vlmax;

    // requested vtype and application vector length
    assign vtype_req = (vsetvl_type == VSETVL) ? vtype_t'(rs2_val) : vtype_imm;
    assign avl       = (vsetvl_type == VSETIVLI) ? {27'b0, zimm} : rs1_val;

    assign sew     = vsew_t'(vtype_req[VSEW_LSB +: 3]);
    assign lmul    = vlmul_t'(vtype_req[VLMUL_LSB +: 3]);
    // reserved field sits between vsew and vill
    assign rsvd_ok = (vtype_req[VILL_BIT-1:VSEW_LSB+3] == '0);

    // elements per register for this sew
    always_comb begin
        sew_ok = 1'b1;
        case (sew)
            SEW8:    vlmax_sew = VLEN_W;
            SEW16:   vlmax_sew = VLEN_W >> 1;
            SEW32:   vlmax_sew = VLEN_W >> 2;
            default: begin
                sew_ok    = 1'b0;
                vlmax_sew = '0;
            end
        endcase
    end

    // scale by register group size
    always_comb begin
        lmul_ok = 1'b1;
        case (lmul)
            LMUL1:      vlmax = vlmax_sew;
            LMUL2:      vlmax = vlmax_sew << 1;
            LMUL4:      vlmax = vlmax_sew << 2;
            LMUL8:      vlmax = vlmax_sew << 3;
            LMULHALF:   vlmax = vlmax_sew >> 1;
            LMULFOURTH: vlmax = vlmax_sew >> 2;
            LMULEIGHTH: vlmax = vlmax_sew >> 3;
            default: begin
                lmul_ok = 1'b0;
                vlmax   = '0;
            end
        endcase
    end

    // rs1 = x0 asks for vlmax, except on vsetivli
    assign keep_max = (rs1 == '0) && ((vsetvl_type == VSETVL) || (vsetvl_type == VSETVLI));

    always_comb begin
        new_vtype = vtype_req;
        if (!(sew_ok && lmul_ok && rsvd_ok)) begin
            // illegal config: only vill, and vl forced to zero
            new_vtype           = '0;
            new_vtype[VILL_BIT] = 1'b1;
            new_vl              = '0;
        end else if (keep_max) begin
            new_vl = vlmax;
        end else begin
            // strip-mining clamp
            new_vl = (avl < vlmax) ? avl : vlmax;
        end
    end

endmodule

// ==== src/execute_stage.sv ====
/*
    execute stage of the in-order RV32I pipeline with vector configuration
    operands, alu, branch resolution and vl/vtype feed the EX/MEM register
*/
`timescale 1ns/1ns

module execute_stage import ex_pkg::*; #(
    parameter int VLEN_BYTES = 16
) (
    input  logic         CLK,
    input  logic         nRST,
    // decoded instruction
    input  logic         valid,
    input  word_t        pc,
    input  reg_idx_t     rs1,
    input  reg_idx_t     rs2,
    input  reg_idx_t     rd,
    input  logic         wen,
    input  logic         illegal,
    input  alu_op_t      alu_op,
    input  alu_a_sel_t   alu_a_sel,
    input  alu_b_sel_t   alu_b_sel,
    input  logic         imm_shamt_sel,
    input  logic [4:0]   shamt,
    input  logic [11:0]  imm_i,
    input  logic [11:0]  imm_s,
    input  logic [12:0]  imm_sb,
    input  logic [20:0]  imm_uj,
    input  word_t        imm_u,
    input  branch_type_t branch_type,
    input  logic         j_sel,
    input  logic         ex_pc_sel,
    input  vsetvl_type_t vsetvl_type,
    input  vtype_t       vtype_imm,
    input  logic [4:0]   zimm,
    // forwarding from memory stage
    input  logic         fwd_rs1,
    input  logic         fwd_rs2,
    input  word_t        fwd_data,
    // write-back port
    input  logic         wb_wen,
    input  reg_idx_t     wb_rd,
    input  word_t        wb_data,
    // hazard control
    input  logic         stall,
    input  logic         flush,
    // EX/MEM register
    output logic         mem_valid,
    output reg_idx_t     mem_rd,
    output logic         mem_reg_write,
    output logic         mem_illegal,
    output logic         mem_branch_taken,
    output word_t        mem_result,
    output word_t        mem_brj_addr,
    output vtype_t       mem_vtype
);

    word_t  rs1_data;
    word_t  rs2_data;
    word_t  rs1_val;
    word_t  rs2_val;
    word_t  imm_i_ext;
    word_t  imm_s_ext;
    word_t  imm_or_shamt;
    word_t  port_a;
    word_t  port_b;
    word_t  alu_out;
    logic   branch_taken;
    word_t  brj_addr;
    word_t  new_vl;
    vtype_t new_vtype;
    logic   is_cfg;
    word_t  ex_result;
    vtype_t ex_vtype;

    reg_file u_reg_file (
        .CLK      (CLK),
        .nRST     (nRST),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (wb_wen),
        .rd       (wb_rd),
        .w_data   (wb_data)
    );

    // memory stage result replaces the stale register value
    assign rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;

    assign imm_i_ext = {{20{imm_i[11]}}, imm_i};
    assign imm_s_ext = {{20{imm_s[11]}}, imm_s};

    // shift-immediate forms use shamt instead of imm_i
    assign imm_or_shamt = imm_shamt_sel ? {27'b0, shamt} : imm_i_ext;

    always_comb begin
        case (alu_a_sel)
            A_RS1:   port_a = rs1_val;
            A_IMM_S: port_a = imm_s_ext;
            A_PC:    port_a = pc;
            default: port_a = '0;
        endcase
    end

    always_comb begin
        case (alu_b_sel)
            B_RS1:   port_b = rs1_val;
            B_RS2:   port_b = rs2_val;
            B_IMM:   port_b = imm_or_shamt;
            default: port_b = imm_u;
        endcase
    end

    alu u_alu (
        .aluop    (alu_op),
        .port_a   (port_a),
        .port_b   (port_b),
        .port_out (alu_out)
    );

    branch_jump_unit u_branch_jump_unit (
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .branch_type  (branch_type),
        .imm_sb       (imm_sb),
        .imm_uj       (imm_uj),
        .imm_i_ext    (imm_i_ext),
        .j_sel        (j_sel),
        .ex_pc_sel    (ex_pc_sel),
        .branch_taken (branch_taken),
        .brj_addr     (brj_addr)
    );

    vcfg_unit #(
        .VLEN_BYTES (VLEN_BYTES)
    ) u_vcfg_unit (
        .vsetvl_type (vsetvl_type),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1         (rs1),
        .zimm        (zimm),
        .vtype_imm   (vtype_imm),
        .new_vl      (new_vl),
        .new_vtype   (new_vtype)
    );

    // config instructions write vl to rd
    assign is_cfg    = (vsetvl_type != NOT_CFG);
    assign ex_result = is_cfg ? new_vl : alu_out;
    assign ex_vtype  = is_cfg ? new_vtype : '0;

    // stall beats flush
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_valid        <= 1'b0;
            mem_rd           <= '0;
            mem_reg_write    <= 1'b0;
            mem_illegal      <= 1'b0;
            mem_branch_taken <= 1'b0;
            mem_result       <= '0;
            mem_brj_addr     <= '0;
            mem_vtype        <= '0;
        end else if (!stall) begin
            if (flush) begin
                mem_valid        <= 1'b0;
                mem_rd           <= '0;
                mem_reg_write    <= 1'b0;
                mem_illegal      <= 1'b0;
                mem_branch_taken <= 1'b0;
                mem_result       <= '0;
                mem_brj_addr     <= '0;
                mem_vtype        <= '0;
            end else begin
                mem_valid        <= valid;
                mem_rd           <= rd;
                // illegal squashes the control bits
                mem_reg_write    <= wen && !illegal;
                mem_branch_taken <= branch_taken && !illegal;
                mem_illegal      <= illegal;
                mem_result       <= ex_result;
                mem_brj_addr     <= brj_addr;
                mem_vtype        <= ex_vtype;
            end
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
/*
    clock and reset source for the execute stage testbench
    4 ns clock, reset held low for the first 16 rising edges
*/
`timescale 1ns/1ns

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // release on a falling edge so the first stimulus is set up cleanly
    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// ==== testbench/tb_execute_stage.sv ====
/*
    directed testbench for the execute stage, built and run by the Makefile
    inputs change on the falling edge and EX/MEM outputs are read one cycle later
*/
`timescale 1ns/1ns

module tb_execute_stage import ex_pkg::*; ();

    localparam int VLEN_BYTES  = 16;
    // the tests need a few hundred cycles
    localparam int CYCLE_LIMIT = 2000;

    logic         CLK;
    logic         nRST;
    logic         valid, wen, illegal;
    word_t        pc;
    reg_idx_t     rs1, rs2, rd;
    alu_op_t      alu_op;
    alu_a_sel_t   alu_a_sel;
    alu_b_sel_t   alu_b_sel;
    logic         imm_shamt_sel;
    logic [4:0]   shamt;
    logic [11:0]  imm_i, imm_s;
    logic [12:0]  imm_sb;
    logic [20:0]  imm_uj;
    word_t        imm_u;
    branch_type_t branch_type;
    logic         j_sel, ex_pc_sel;
    vsetvl_type_t vsetvl_type;
    vtype_t       vtype_imm;
    logic [4:0]   zimm;
    logic         fwd_rs1, fwd_rs2;
    word_t        fwd_data;
    logic         wb_wen;
    reg_idx_t     wb_rd;
    word_t        wb_data;
    logic         stall, flush;
    logic         mem_valid, mem_reg_write, mem_illegal, mem_branch_taken;
    reg_idx_t     mem_rd;
    word_t        mem_result, mem_brj_addr;
    vtype_t       mem_vtype;

    // register contents as written through the write-back port
    word_t        reg_model [32];
    logic [31:0]  lfsr_state;
    int           cycles = 0;

    tb_clock u_clock (
        .CLK  (CLK),
        .nRST (nRST)
    );

    execute_stage #(
        .VLEN_BYTES (VLEN_BYTES)
    ) dut (.*);

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t sign_extend(input word_t v, input int bits);
        return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    // reference alu from the RV32I definitions
    function automatic word_t alu_expect(input alu_op_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;
            ALU_SLL:  r = a << sh;
            // differing signs decide a signed compare on their own
            ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: r = {31'b0, a < b};
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic logic branch_expect(input branch_type_t bt, input word_t a, input word_t b);
        word_t sa;
        word_t sb;
        // flipped sign bits make the signed order an unsigned one
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        case (bt)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return sa < sb;
            BR_GE:   return !(sa < sb);
            BR_LTU:  return a < b;
            BR_GEU:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // elements = vlen bits * lmul / sew bits
    function automatic word_t vlmax_expect(input int sew, input int lmul);
        int bits;
        bits = VLEN_BYTES * 8;
        if (lmul < 4) begin
            bits = bits << lmul;
        end else begin
            bits = bits >> (8 - lmul);
        end
        return word_t'(bits / (8 << sew));
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_vtype(input string name, input vtype_t got, input vtype_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_mem(input logic e_valid, input reg_idx_t e_rd, input logic e_write,
                             input logic e_illegal, input logic e_taken, input word_t e_result,
                             input word_t e_addr, input vtype_t e_vtype);
        check_bit("mem_valid", mem_valid, e_valid);
        check_idx("mem_rd", mem_rd, e_rd);
        check_bit("mem_reg_write", mem_reg_write, e_write);
        check_bit("mem_illegal", mem_illegal, e_illegal);
        check_bit("mem_branch_taken", mem_branch_taken, e_taken);
        check_word("mem_result", mem_result, e_result);
        check_word("mem_brj_addr", mem_brj_addr, e_addr);
        check_vtype("mem_vtype", mem_vtype, e_vtype);
    endtask

    // bubble that adds x0 to x0 at pc 0 with no hazards
    task automatic clear_inputs();
        valid = 1'b0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        wen = 1'b0;
        illegal = 1'b0;
        alu_op = ALU_ADD;
        alu_a_sel = A_RS1;
        alu_b_sel = B_RS2;
        imm_shamt_sel = 1'b0;
        shamt = '0;
        imm_i = '0;
        imm_s = '0;
        imm_sb = '0;
        imm_uj = '0;
        imm_u = '0;
        branch_type = BR_NONE;
        j_sel = 1'b0;
        ex_pc_sel = 1'b0;
        vsetvl_type = NOT_CFG;
        vtype_imm = '0;
        zimm = '0;
        fwd_rs1 = 1'b0;
        fwd_rs2 = 1'b0;
        fwd_data = '0;
        wb_wen = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        stall = 1'b0;
        flush = 1'b0;
    endtask

    // EX/MEM loads on the rising edge and is read back on the falling one
    task automatic next_cycle();
        @(posedge CLK);
        @(negedge CLK);
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t value);
        clear_inputs();
        wb_wen = 1'b1;
        wb_rd = idx;
        wb_data = value;
        next_cycle();
        // the bubble itself loads as an invalid instruction
        check_mem(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 32'd4, '0);
        if (idx != '0) begin
            reg_model[idx] = value;
        end
    endtask

    task automatic test_reset();
        check_mem(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic test_alu();
        word_t   v;
        word_t   a;
        word_t   b;
        alu_op_t op;
        for (int i = 1; i < 32; i++) begin
            rand_bits(32, v);
            write_reg(reg_idx_t'(i), v);
        end
        // write to x0 must not stick
        rand_bits(32, v);
        write_reg('0, v);
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 10; k++) begin
                op = alu_op_t'(k);
                // form 0 uses rs2, 1 the sign-extended imm_i and 2 the shamt
                for (int form = 0; form < 3; form++) begin
                    clear_inputs();
                    valid = 1'b1;
                    wen = 1'b1;
                    alu_op = op;
                    rand_bits(5, v);
                    rs1 = v[4:0];
                    rand_bits(5, v);
                    rs2 = v[4:0];
                    rand_bits(5, v);
                    rd = v[4:0];
                    rand_bits(30, v);
                    pc = {v[29:0], 2'b00};
                    rand_bits(12, v);
                    imm_i = v[11:0];
                    // non-config instructions leave mem_vtype at zero
                    rand_bits(32, v);
                    vtype_imm = v;
                    a = reg_model[rs1];
                    b = reg_model[rs2];
                    if (form == 1) begin
                        alu_b_sel = B_IMM;
                        b = sign_extend(word_t'(imm_i), 12);
                    end else if (form == 2) begin
                        alu_b_sel = B_IMM;
                        imm_shamt_sel = 1'b1;
                        rand_bits(5, v);
                        shamt = v[4:0];
                        b = word_t'(shamt);
                    end
                    next_cycle();
                    check_mem(1'b1, rd, 1'b1, 1'b0, 1'b0, alu_expect(op, a, b), pc + 32'd4, '0);
                end
            end
        end
        // x0 reads back as zero
        clear_inputs();
        valid = 1'b1;
        alu_op = ALU_OR;
        next_cycle();
        check_word("mem_result", mem_result, '0);
    endtask

    task automatic test_forwarding();
        word_t f;
        for (int sel = 1; sel < 4; sel++) begin
            clear_inputs();
            rand_bits(32, f);
            valid = 1'b1;
            wen = 1'b1;
            rd = 5'd9;
            rs1 = 5'd3;
            rs2 = 5'd4;
            alu_op = ALU_SUB;
            fwd_rs1 = sel[0];
            fwd_rs2 = sel[1];
            fwd_data = f;
            next_cycle();
            check_mem(1'b1, 5'd9, 1'b1, 1'b0, 1'b0,
                      alu_expect(ALU_SUB, sel[0] ? f : reg_model[3], sel[1] ? f : reg_model[4]),
                      32'd4, '0);
        end
    endtask

    task automatic test_branches();
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    v;
        logic     tk;
        // an equal pair and a negative against a small positive in both orders
        write_reg(5'd1, 32'd5);
        write_reg(5'd2, 32'd5);
        write_reg(5'd3, 32'hffff_fff0);
        write_reg(5'd4, 32'd7);
        for (int t = 0; t < 7; t++) begin
            for (int p = 0; p < 3; p++) begin
                ra = (p == 0) ? 5'd1 : (p == 1) ? 5'd3 : 5'd4;
                rb = (p == 0) ? 5'd2 : (p == 1) ? 5'd4 : 5'd3;
                clear_inputs();
                valid = 1'b1;
                rs1 = ra;
                rs2 = rb;
                branch_type = branch_type_t'(t);
                rand_bits(30, v);
                pc = {v[29:0], 2'b00};
                rand_bits(12, v);
                imm_sb = {v[11:0], 1'b0};
                tk = branch_expect(branch_type, reg_model[ra], reg_model[rb]);
                next_cycle();
                check_mem(1'b1, '0, 1'b0, 1'b0, tk, reg_model[ra] + reg_model[rb],
                          tk ? pc + sign_extend(word_t'(imm_sb), 13) : pc + 32'd4, '0);
            end
        end
        for (int n = 0; n < 4; n++) begin
            // jal with the link value pc + 4 built from A_PC and B_IMM_U
            clear_inputs();
            valid = 1'b1;
            wen = 1'b1;
            rd = 5'd1;
            rand_bits(30, v);
            pc = {v[29:0], 2'b00};
            rand_bits(20, v);
            imm_uj = {v[19:0], 1'b0};
            alu_a_sel = A_PC;
            alu_b_sel = B_IMM_U;
            imm_u = 32'd4;
            ex_pc_sel = 1'b1;
            j_sel = 1'b1;
            next_cycle();
            check_mem(1'b1, 5'd1, 1'b1, 1'b0, 1'b0, pc + 32'd4,
                      pc + sign_extend(word_t'(imm_uj), 21), '0);
            // jalr from x3 with target bit 0 cleared
            j_sel = 1'b0;
            rs1 = 5'd3;
            rand_bits(12, v);
            imm_i = v[11:0];
            next_cycle();
            check_mem(1'b1, 5'd1, 1'b1, 1'b0, 1'b0, pc + 32'd4,
                      (reg_model[3] + sign_extend(word_t'(imm_i), 12)) & 32'hffff_fffe, '0);
        end
    endtask

    task automatic run_cfg(input vsetvl_type_t kind, input reg_idx_t src, input word_t avl,
                           input vtype_t vt, input word_t exp_vl, input vtype_t exp_vt);
        clear_inputs();
        valid = 1'b1;
        wen = 1'b1;
        rd = 5'd10;
        vsetvl_type = kind;
        rs1 = src;
        zimm = avl[4:0];
        // vsetvl reads vtype from rs2 and the others from the immediate
        if (kind == VSETVL) begin
            fwd_rs2 = 1'b1;
            fwd_data = vt;
        end else begin
            vtype_imm = vt;
            fwd_rs1 = 1'b1;
            fwd_data = avl;
        end
        next_cycle();
        check_mem(1'b1, 5'd10, 1'b1, 1'b0, 1'b0, exp_vl, 32'd4, exp_vt);
    endtask

    task automatic test_vcfg();
        vtype_t vt;
        vtype_t ill;
        word_t  vmax;
        word_t  v;
        ill = vtype_t'(1) << VILL_BIT;
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 8; l++) begin
                if (l != 4) begin
                    vt = vtype_t'((s << VSEW_LSB) | (l << VLMUL_LSB));
                    vmax = vlmax_expect(s, l);
                    rand_bits(4, v);
                    run_cfg(VSETVLI, 5'd5, (vmax == 0) ? '0 : vmax - 32'd1, vt,
                            (vmax == 0) ? '0 : vmax - 32'd1, vt);
                    run_cfg(VSETVLI, 5'd5, vmax + 32'd1 + v, vt, vmax, vt);
                    // rs1 = x0 asks for vlmax
                    run_cfg(VSETVLI, '0, v, vt, vmax, vt);
                    run_cfg(VSETVL, '0, '0, vt, vmax, vt);
                    // vsetivli with x0 in rs1 still clamps zimm
                    rand_bits(5, v);
                    run_cfg(VSETIVLI, '0, v, vt, (v < vmax) ? v : vmax, vt);
                end
            end
        end
        for (int s = 3; s < 8; s++) begin
            run_cfg(VSETVLI, 5'd5, 32'd3, vtype_t'(s << VSEW_LSB), '0, ill);
        end
        run_cfg(VSETVLI, 5'd5, 32'd3, vtype_t'(4 << VLMUL_LSB), '0, ill);
        run_cfg(VSETVL, '0, '0, 32'h0000_0040, '0, ill);
        run_cfg(VSETIVLI, '0, 32'd3, 32'h4000_0000, '0, ill);
    endtask

    task automatic test_hazards();
        word_t held;
        clear_inputs();
        valid = 1'b1;
        wen = 1'b1;
        rd = 5'd11;
        rs1 = 5'd1;
        rs2 = 5'd4;
        held = reg_model[1] + reg_model[4];
        next_cycle();
        check_mem(1'b1, 5'd11, 1'b1, 1'b0, 1'b0, held, 32'd4, '0);
        // a new instruction under stall and then stall together with flush
        rs1 = 5'd3;
        rd = 5'd12;
        stall = 1'b1;
        next_cycle();
        check_mem(1'b1, 5'd11, 1'b1, 1'b0, 1'b0, held, 32'd4, '0);
        flush = 1'b1;
        next_cycle();
        check_mem(1'b1, 5'd11, 1'b1, 1'b0, 1'b0, held, 32'd4, '0);
        stall = 1'b0;
        next_cycle();
        check_mem(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        // illegal taken beq with a write enable
        clear_inputs();
        valid = 1'b1;
        wen = 1'b1;
        illegal = 1'b1;
        rd = 5'd13;
        rs1 = 5'd1;
        rs2 = 5'd2;
        branch_type = BR_EQ;
        imm_sb = 13'h010;
        next_cycle();
        check_mem(1'b1, 5'd13, 1'b0, 1'b1, 1'b0, reg_model[1] + reg_model[2], 32'h10, '0);
    endtask

    initial begin
        lfsr_state = 32'h9857;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        clear_inputs();
        @(posedge nRST);
        test_reset();
        test_alu();
        test_forwarding();
        test_branches();
        test_vcfg();
        test_hazards();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== execute_stage.f ====
src/ex_pkg.sv
src/reg_file.sv
src/alu.sv
src/branch_jump_unit.sv
src/vcfg_unit.sv
src/execute_stage.sv
testbench/tb_clock.sv
testbench/tb_execute_stage.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench
.PHONY: simulate clean

simulate:
	verilator --binary --timing --top-module tb_execute_stage -f execute_stage.f
	./obj_dir/Vtb_execute_stage | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
